/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/div_unit_tb.sv */
// testbench for the divide unit, run through div_unit.f with the Makefile sim target
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;
    import div_types_pkg::*;

    logic            CLK;
    logic            nRST;
    logic            req;
    logic [1:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            ack;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] expected;
    logic            started;
    integer          seed;
    int              value_errors;
    int              shake_errors;
    int              timeouts;

    div_unit dut0 (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (req),
        .op     (op),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // --------------------------------------------------
    // golden model from the RISC-V divide rules

    function automatic logic [XLEN-1:0] ref_result(div_op_t f_op, logic [XLEN-1:0] x,
                                                   logic [XLEN-1:0] y);
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (!f_op[0] && x == 32'h8000_0000 && y == 32'hFFFF_FFFF) begin
            q = x;
            r = '0;
        end else if (f_op[0]) begin
            q = x / y;
            r = x % y;
        end else begin
            // truncating so the remainder keeps the dividend sign
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end
        return f_op[1] ? r : q;
    endfunction

    // --------------------------------------------------
    // checks

    a_idle: assert property (@(posedge CLK) disable iff (!nRST) !started |-> !ack)
        else begin
            shake_errors++;
            $display("ack went high before any request was made");
        end
    a_value: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ack) |-> (result == expected))
        else begin
            value_errors++;
            $display("Error: result 0x%08h expected 0x%08h", result, expected);
        end
    a_rise: assert property (@(posedge CLK) disable iff (!nRST) $rose(ack) |-> $past(req))
        else begin
            shake_errors++;
            $display("ack rose while req was low");
        end
    a_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (ack && req) |=> (ack && $stable(result)))
        else begin
            shake_errors++;
            $display("ack or result changed while req was still high");
        end
    a_fall: assert property (@(posedge CLK) disable iff (!nRST) (ack && !req) |=> !ack)
        else begin
            shake_errors++;
            $display("ack stayed high after req fell");
        end

    // --------------------------------------------------
    // stimulus

    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic transfer(div_op_t t_op, logic [XLEN-1:0] x, logic [XLEN-1:0] y,
                            int hold);
        int n;
        expected = ref_result(t_op, x, y);
        op       = t_op;
        a        = x;
        b        = y;
        req      = 1'b1;
        started  = 1'b1;
        n = 0;
        while (!ack && n < 100) begin
            step();
            n++;
        end
        if (!ack) begin
            timeouts++;
            $display("no ack within 100 cycles of the request");
            req = 1'b0;
            return;
        end
        repeat (hold) step();
        req = 1'b0;
        n = 0;
        while (ack && n < 10) begin
            step();
            n++;
        end
        if (ack) begin
            timeouts++;
            $display("ack did not fall within 10 cycles after req fell");
        end
    endtask

    // each operand pair goes through all four ops
    task automatic all_ops(logic [XLEN-1:0] x, logic [XLEN-1:0] y);
        int hold;
        for (int k = 0; k < 4 && timeouts == 0; k++) begin
            hold = $unsigned($random(seed)) % 4;
            transfer(div_op_t'(k[1:0]), x, y, hold);
        end
    endtask

    initial begin
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        int sh;
        seed         = 93;
        nRST         = 1'b0;
        req          = 1'b0;
        op           = 2'b00;
        a            = '0;
        b            = '0;
        expected     = '0;
        started      = 1'b0;
        value_errors = 0;
        shake_errors = 0;
        timeouts     = 0;
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        repeat (6) step();

        // zero divisor, overflow and sign combinations
        all_ops(32'h0000_1234, 32'h0);
        all_ops(32'h8000_0000, 32'h0);
        all_ops(32'hFFFF_FFF9, 32'h0);
        all_ops(32'h8000_0000, 32'hFFFF_FFFF);
        all_ops(32'd7, 32'd2);
        all_ops(32'hFFFF_FFF9, 32'd2);
        all_ops(32'd7, 32'hFFFF_FFFE);
        all_ops(32'hFFFF_FFF9, 32'hFFFF_FFFE);
        all_ops(32'd5, 32'd7);
        all_ops(32'd0, 32'd3);
        all_ops(32'hFFFF_FFFF, 32'd1);

        for (int i = 0; i < 200 && timeouts == 0; i++) begin
            x = $random(seed);
            y = $random(seed);
            all_ops(x, y);
        end
        // small magnitudes for skipping and early exit
        for (int i = 0; i < 100 && timeouts == 0; i++) begin
            sh = $unsigned($random(seed)) % 32;
            x  = $signed($random(seed)) >>> sh;
            sh = $unsigned($random(seed)) % 32;
            y  = $signed($random(seed)) >>> sh;
            all_ops(x, y);
        end

        repeat (4) step();
        $display("value errors %0d, handshake errors %0d, timeouts %0d",
                 value_errors, shake_errors, timeouts);
        if (value_errors == 0 && shake_errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* div_unit.f */
logic/div_types_pkg.sv
logic/div_fsm_pkg.sv
logic/div_if.sv
logic/msb_encoder.sv
logic/div32_nonrestoring_skip.sv
logic/div_issue_ctrl.sv
logic/div_unit.sv
bench/div_unit_tb.sv

/* logic/div32_nonrestoring_skip.sv */
// multi-cycle 32-bit divider started by clear low and answering with a done pulse
`timescale 1ns/1ps
`default_nettype none

module div32_nonrestoring_skip (
    input logic CLK,
    input logic nRST,
    div_if.core dif
);
    import div_types_pkg::*;
    import div_fsm_pkg::*;

    // --------------------------------------------------
    // signals

    div_state_t state, next_state;

    logic             a_neg;
    logic             b_neg;
    logic             b_zero;

    // magnitudes with one spare bit for the sign
    logic [XLEN:0]    a_abs, next_a_abs;
    logic [XLEN:0]    b_abs;
    logic [XLEN:0]    b_abs_neg;

    logic [IDX_W-1:0] msb_index, next_msb_index;
    logic [XLEN-1:0]  msb_mask, next_msb_mask;
    logic [IDX_W-1:0] counter;

    // partial remainder and quotient shift register
    logic [XLEN:0]    acc, next_acc;
    logic [XLEN-1:0]  quot, next_quot;
    logic [XLEN:0]    acc_shift;

    // --------------------------------------------------
    // registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= DIV_INIT;
            a_neg     <= 1'b0;
            b_neg     <= 1'b0;
            b_zero    <= 1'b0;
            a_abs     <= '0;
            b_abs     <= '0;
            b_abs_neg <= '0;
            msb_index <= '0;
            msb_mask  <= '0;
            counter   <= '0;
            acc       <= '0;
            quot      <= '0;
        end else begin
            state <= dif.clear ? DIV_INIT : next_state;

            // operands are held by the controller for the whole divide
            a_neg  <= dif.is_signed & dif.a[XLEN-1];
            b_neg  <= dif.is_signed & dif.b[XLEN-1];
            b_zero <= (dif.b == '0);
            a_abs  <= next_a_abs;
            if (dif.is_signed & dif.b[XLEN-1]) begin
                b_abs     <= -{1'b1, dif.b};
                b_abs_neg <= {1'b1, dif.b};
            end else begin
                b_abs     <= {1'b0, dif.b};
                b_abs_neg <= -{1'b0, dif.b};
            end

            // leading zeros of the dividend are skipped
            if (state == DIV_INIT) begin
                msb_index <= next_msb_index;
                msb_mask  <= next_msb_mask;
                counter   <= next_msb_index;
            end else begin
                counter <= counter - 1'b1;
            end

            // results hold while idle
            if (!dif.clear) begin
                acc  <= next_acc;
                quot <= next_quot;
            end
        end
    end

    msb_encoder msb_enc0 (
        .vec   (next_a_abs[XLEN-1:0]),
        .index (next_msb_index),
        .mask  (next_msb_mask)
    );

    // --------------------------------------------------
    // next state and datapath

    always_comb begin
        if (dif.is_signed & dif.a[XLEN-1]) begin
            next_a_abs = -{1'b1, dif.a};
        end else begin
            next_a_abs = {1'b0, dif.a};
        end

        // next dividend bit enters from the top of the window
        acc_shift  = {acc[XLEN-1:0], quot[msb_index]};
        next_state = state;
        next_acc   = acc;
        next_quot  = quot;

        case (state)
            DIV_INIT: begin
                next_state = DIV_ITERS;
                next_acc   = '0;
                next_quot  = next_a_abs[XLEN-1:0];
            end
            DIV_ITERS: begin
                if (b_zero) begin
                    next_state = DIV_DONE;
                    next_acc   = {1'b0, dif.a};
                    next_quot  = '1;
                end else if (a_abs < b_abs) begin
                    next_state = DIV_DONE;
                    next_acc   = {1'b0, dif.a};
                    next_quot  = '0;
                end else begin
                    next_state = (counter == '0) ? DIV_CORRECTION : DIV_ITERS;
                    // add back after a negative step
                    if (acc[XLEN]) begin
                        next_acc = acc_shift + b_abs;
                    end else begin
                        next_acc = acc_shift + b_abs_neg;
                    end
                    next_quot = {quot[XLEN-2:0], ~next_acc[XLEN]} & msb_mask;
                end
            end
            DIV_CORRECTION: begin
                next_state = DIV_DONE;
                // restore a negative remainder
                next_acc = acc + (b_abs & {(XLEN + 1){acc[XLEN]}});
                // remainder takes the dividend sign
                if (a_neg) begin
                    next_acc = -next_acc;
                end
                if (a_neg ^ b_neg) begin
                    next_quot = -quot;
                end
            end
            default: begin
                next_state = DIV_INIT;
            end
        endcase
    end

    assign dif.done      = (state == DIV_DONE);
    assign dif.quotient  = quot;
    assign dif.remainder = acc[XLEN-1:0];

    // --------------------------------------------------
    // checks

    // one done pulse per divide
    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        dif.done |=> !dif.done);

    // last iteration must leave the loop
    a_iter_no_wrap: assert property (@(posedge CLK) disable iff (!nRST)
        (state == DIV_ITERS && counter == '0) |=> (state != DIV_ITERS));

endmodule

`default_nettype wire

/* logic/div_fsm_pkg.sv */
// divider state encoding and counter width imported by the encoder and divider
`default_nettype none

package div_fsm_pkg;

    // bit index of a 32-bit word
    localparam int IDX_W = 5;

    // --------------------------------------------------
    // divider sequence

    typedef enum logic [1:0] {
        DIV_INIT,
        DIV_ITERS,
        DIV_CORRECTION,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

/* logic/div_if.sv */
// link between issue controller and divider that the top level instantiates once
`timescale 1ns/1ps
`default_nettype none

interface div_if;
    import div_types_pkg::*;

    // request side
    logic            clear;
    logic            is_signed;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;

    // results hold until the next start
    logic            done;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;

    modport ctrl (
        output clear, is_signed, a, b,
        input  done, quotient, remainder
    );

    modport core (
        input  clear, is_signed, a, b,
        output done, quotient, remainder
    );

endinterface

`default_nettype wire

/* logic/div_issue_ctrl.sv */
// four-phase request handler that latches operands and feeds the divider
`timescale 1ns/1ps
`default_nettype none

module div_issue_ctrl (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           req,
    input  div_types_pkg::div_op_t         op,
    input  logic [div_types_pkg::XLEN-1:0] a,
    input  logic [div_types_pkg::XLEN-1:0] b,
    output logic                           ack,
    output logic [div_types_pkg::XLEN-1:0] result,
    div_if.ctrl                            dif
);
    import div_types_pkg::*;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_BUSY,
        CTRL_ANSWER
    } ctrl_state_t;

    ctrl_state_t     state;
    div_op_t         op_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;

    // --------------------------------------------------
    // handshake

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= CTRL_IDLE;
            op_q   <= OP_DIV;
            a_q    <= '0;
            b_q    <= '0;
            result <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (req) begin
                        op_q  <= op;
                        a_q   <= a;
                        b_q   <= b;
                        state <= CTRL_BUSY;
                    end
                end
                CTRL_BUSY: begin
                    if (dif.done) begin
                        result <= op_q[1] ? dif.remainder : dif.quotient;
                        state  <= CTRL_ANSWER;
                    end
                end
                CTRL_ANSWER: begin
                    // wait for the requester to drop req
                    if (!req) begin
                        state <= CTRL_IDLE;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    assign ack           = (state == CTRL_ANSWER);
    // divider runs only while busy
    assign dif.clear     = (state != CTRL_BUSY);
    assign dif.is_signed = ~op_q[0];
    assign dif.a         = a_q;
    assign dif.b         = b_q;

    // ack follows req in both directions
    a_ack_rise: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ack) |-> $past(req));
    a_ack_fall: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(ack) |-> !$past(req));

endmodule

`default_nettype wire

/* logic/div_types_pkg.sv */
// word width and divide op codes shared by the RTL and the testbench through import
`default_nettype none

package div_types_pkg;

    // --------------------------------------------------
    // data path

    localparam int XLEN = 32;

    // --------------------------------------------------
    // operation codes

    // bit 0 set selects unsigned
    // bit 1 set returns the remainder
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_t;

endpackage

`default_nettype wire

/* logic/div_unit.sv */
// divide unit top level that a core or testbench drives through req and ack
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           req,
    input  logic [1:0]                     op,
    input  logic [div_types_pkg::XLEN-1:0] a,
    input  logic [div_types_pkg::XLEN-1:0] b,
    output logic                           ack,
    output logic [div_types_pkg::XLEN-1:0] result
);
    import div_types_pkg::*;

    div_op_t op_enum;

    assign op_enum = div_op_t'(op);

    div_if dif0 ();

    div_issue_ctrl ctrl0 (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (req),
        .op     (op_enum),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result),
        .dif    (dif0)
    );

    div32_nonrestoring_skip div0 (
        .CLK  (CLK),
        .nRST (nRST),
        .dif  (dif0)
    );

endmodule

`default_nettype wire

/* logic/msb_encoder.sv */
// combinational highest-set-bit finder giving index and fill mask for the divider
`timescale 1ns/1ps
`default_nettype none

module msb_encoder (
    input  logic [div_types_pkg::XLEN-1:0] vec,
    output logic [div_fsm_pkg::IDX_W-1:0]  index,
    output logic [div_types_pkg::XLEN-1:0] mask
);
    import div_types_pkg::*;
    import div_fsm_pkg::*;

    // scan downward so the first set bit seen is the top one
    always_comb begin
        logic seen;
        seen  = 1'b0;
        index = '0;
        mask  = '0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (vec[i] && !seen) begin
                index = IDX_W'(i);
            end
            seen    = seen | vec[i];
            // ones from the top bit down
            mask[i] = seen;
        end
    end

endmodule

`default_nettype wire
